//--- files.f
+incdir+.
CoreIsaTypes.sv
CoreControlTypes.sv
ControlLogic.sv
RegisterFile.sv
Alu.sv
ImmediateFormer.sv
BranchUnit.sv
MemoryController.sv
CoreTop.sv
CoreTb.sv

//--- CoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module CoreTb;
	// Major opcodes with the low bits set
	localparam logic [6:0] opLoad = 7'b0000011, opFence = 7'b0001111, opImm = 7'b0010011;
	localparam logic [6:0] opAuipc = 7'b0010111, opStore = 7'b0100011, opReg = 7'b0110011;
	localparam logic [6:0] opLui = 7'b0110111, opBranch = 7'b1100011, opJalr = 7'b1100111;
	localparam logic [6:0] opJal = 7'b1101111, opSystem = 7'b1110011;
	localparam logic [31:0] ecallWord = 32'h0000_0073, ebreakWord = 32'h0010_0073;
	// Halt causes as seen on haltCause
	localparam logic [2:0] causeNone = 3'd0, causeStop = 3'd1, causeBadOpcode = 3'd2;
	localparam logic [2:0] causeBadLowOpcode = 3'd3, causePcMisaligned = 3'd4;
	localparam logic [2:0] causeUnaligned = 3'd5, causeBadFunct3 = 3'd6;

	logic clock, reset, loadStrobe;
	logic [`MEM_ADDR_BITS-1:0] loadAddress;
	logic [31:0] loadData;
	logic retireStrobe, retireWrite, halted;
	logic [31:0] retirePc, retireValue;
	logic [4:0] retireRd;
	logic [2:0] haltCause;

	logic [31:0] prog [$]; // Assembled program with word 0 at RESET_PC
	logic [31:0] modelMemory [`MEM_WORDS];
	logic [31:0] modelRegs [32];
	logic [31:0] modelPc;
	logic modelHalted;
	logic [31:0] expectedPc, expectedValue; // Filled by modelStep
	logic expectedWrite;
	logic [4:0] expectedRd;
	logic running; // Comparing process active
	logic [15:0] lfsrState;
	int errorCount, testCount, failedTests, retireCount;

	CoreTop dut0
	(
		.clock, .reset, .loadStrobe, .loadAddress, .loadData,
		.retireStrobe, .retirePc, .retireWrite, .retireRd, .retireValue, .halted, .haltCause
	);

	always #10 clock = ~clock;

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = 32'd0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState); // One step per bit
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	// Instruction encoders
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iType(input logic [6:0] op, input logic [4:0] rd,
		input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// Background for words the program leaves untouched
	function automatic logic [31:0] fillWord(input int address);
		return (32'(address) + 32'd1) * 32'h9E37_79B1 ^ 32'h5A5A_0000;
	endfunction

	// Steps the ISA model by one instruction and commits only without a halt
	function automatic logic [2:0] modelStep();
		logic [31:0] ins, a, b, immI, immS, nextPc, value, address, word, mask;
		logic [4:0] shift;
		logic [2:0] f3, cause;
		logic writes, taken, isLoad, isStore, badOp, stop, badF3, unaligned;
		ins = modelMemory[modelPc[`MEM_ADDR_BITS+1:2]];
		f3 = ins[14:12];
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		nextPc = modelPc + 32'd4;
		value = 32'd0;
		mask = 32'd0;
		{writes, taken, isLoad, isStore, badOp, stop, badF3} = 7'd0;
		address = a + (ins[5] ? immS : immI); // Bit 5 set for stores
		shift = {address[1:0], 3'b000};
		word = modelMemory[address[`MEM_ADDR_BITS+1:2]];
		case ({ins[6:2], 2'b11})
			opLui:
			begin
				writes = 1'b1;
				value = {ins[31:12], 12'b0};
			end
			opAuipc:
			begin
				writes = 1'b1;
				value = modelPc + {ins[31:12], 12'b0};
			end
			opJal:
			begin
				writes = 1'b1;
				value = modelPc + 32'd4;
				nextPc = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			opJalr:
			begin
				writes = 1'b1;
				value = modelPc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
			end
			opBranch:
			begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					3'd7: taken = (a >= b);
					default: badF3 = 1'b1;
				endcase
				if (taken)
					nextPc = modelPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			opLoad:
			begin
				writes = 1'b1;
				isLoad = 1'b1;
				word = word >> shift; // Addressed byte to bit 0
				case (f3)
					3'd0: value = {{24{word[7]}}, word[7:0]};
					3'd1: value = {{16{word[15]}}, word[15:0]};
					3'd2: value = word;
					3'd4: value = {24'd0, word[7:0]};
					3'd5: value = {16'd0, word[15:0]};
					default: badF3 = 1'b1;
				endcase
			end
			opStore:
			begin
				isStore = 1'b1;
				badF3 = (f3 > 3'd2);
			end
			opImm, opReg:
			begin
				writes = 1'b1;
				if (!ins[5])
					b = immI; // OP-IMM
				case (f3)
					3'd0: value = (ins[5] && ins[30]) ? a - b : a + b;
					3'd1: value = a << b[4:0];
					3'd2: value = {31'd0, $signed(a) < $signed(b)};
					3'd3: value = {31'd0, a < b};
					3'd4: value = a ^ b;
					3'd5:
					begin
						if (ins[30])
							value = $signed(a) >>> b[4:0];
						else
							value = a >> b[4:0];
					end
					3'd6: value = a | b;
					default: value = a & b;
				endcase
			end
			opFence:
			begin
				// No effect
			end
			opSystem: stop = 1'b1;
			default: badOp = 1'b1;
		endcase
		unaligned = (isLoad || isStore)
			&& ((f3[1:0] == 2'b01 && address[0]) || (f3[1:0] == 2'b10 && address[1:0] != 2'b00));
		if (ins[1:0] != 2'b11)
			cause = causeBadLowOpcode;
		else if (badOp)
			cause = causeBadOpcode;
		else if (stop)
			cause = causeStop;
		else if (nextPc[1:0] != 2'b00)
			cause = causePcMisaligned;
		else if (unaligned)
			cause = causeUnaligned;
		else if (badF3)
			cause = causeBadFunct3;
		else
			cause = causeNone;
		if (cause == causeNone)
		begin
			if (isStore)
			begin
				case (f3[1:0])
					2'b00: mask = 32'h0000_00ff << shift;
					2'b01: mask = 32'h0000_ffff << shift;
					default: mask = 32'hffff_ffff;
				endcase
				modelMemory[address[`MEM_ADDR_BITS+1:2]] =
					(word & ~mask) | ((b << shift) & mask);
			end
			if (writes && ins[11:7] != 5'd0)
				modelRegs[ins[11:7]] = value;
			expectedPc = modelPc;
			expectedWrite = writes && (ins[11:7] != 5'd0);
			expectedRd = ins[11:7];
			expectedValue = value;
			modelPc = nextPc;
		end
		return cause;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	// Every retire and the halt against the model
	always @(negedge clock)
	begin : compareRetire
		logic [2:0] modelCause;
		if (running && !reset)
		begin
			if (retireStrobe)
			begin
				retireCount++;
				if (modelHalted)
				begin
					$display("Retire at %0t from pc %h after the core should have halted",
						$time, retirePc);
					errorCount++;
				end
				else
				begin
					modelCause = modelStep();
					if (modelCause != causeNone)
					begin
						$display("Instruction at pc %h retired but should halt with cause %0d",
							modelPc, modelCause);
						errorCount++;
						modelHalted = 1'b1;
					end
					else
					begin
						checkValue("retirePc", retirePc, expectedPc);
						checkValue("retireWrite", retireWrite, expectedWrite);
						if (expectedWrite)
						begin
							checkValue("retireRd", retireRd, expectedRd);
							checkValue("retireValue", retireValue, expectedValue);
						end
					end
				end
			end
			else if (halted && !modelHalted)
			begin
				modelCause = modelStep(); // Faulting instruction is not committed
				checkValue("haltCause", haltCause, modelCause);
				modelHalted = 1'b1;
			end
		end
	end

	// Loads under reset, releases it and waits for the halt
	task automatic runProgram(input string name, input logic [2:0] expectedCause);
		int errorsBefore;
		int cycles;
		errorsBefore = errorCount;
		running = 1'b0;
		@(negedge clock);
		reset = 1'b1;
		for (int a = 0; a < `MEM_WORDS; a++)
			modelMemory[a] = (a < prog.size()) ? prog[a] : fillWord(a);
		for (int r = 0; r < 32; r++)
			modelRegs[r] = 32'd0;
		modelPc = `RESET_PC;
		modelHalted = 1'b0;
		retireCount = 0;
		for (int a = 0; a < `MEM_WORDS + 8; a++)
		begin
			loadStrobe = (a < `MEM_WORDS); // Eight idle reset cycles follow
			loadAddress = `MEM_ADDR_BITS'(a);
			loadData = modelMemory[a % `MEM_WORDS];
			@(negedge clock);
			checkValue("retireStrobe", retireStrobe, 1'b0);
			checkValue("halted", halted, 1'b0);
		end
		loadStrobe = 1'b0;
		reset = 1'b0;
		running = 1'b1;
		cycles = 0;
		while (!halted && cycles < 4000)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!halted)
		begin
			$display("Timeout: %s did not halt within %0d cycles", name, cycles);
			errorCount++;
		end
		else
		begin
			repeat (4) @(negedge clock); // Nothing may retire after the halt
			checkValue("haltCause", haltCause, expectedCause);
		end
		running = 1'b0;
		testCount++;
		if (errorCount != errorsBefore)
			failedTests++;
		$display("%s: %0d retired, %0d errors", name, retireCount, errorCount - errorsBefore);
	endtask

	task automatic buildArithmetic();
		logic [4:0] rd;
		prog.delete();
		for (int r = 1; r <= 10; r++)
		begin
			prog.push_back(uType(opLui, 5'(r), 20'(randomBits(20))));
			prog.push_back(iType(opImm, 5'(r), 3'b000, 5'(r), 12'(randomBits(12))));
		end
		prog.push_back(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd0)); // add to x0
		for (int round = 0; round < 4; round++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				rd = 5'd11 + 5'(randomBits(4));
				prog.push_back(rType(7'h00, 5'(randomBits(5)), 5'(randomBits(5)), 3'(k), rd));
				if (k == 0 || k == 5) // sub, sra
					prog.push_back(rType(7'h20, 5'(randomBits(5)), 5'(randomBits(5)), 3'(k), rd));
				if (k == 1 || k == 5) // slli, srli
					prog.push_back(iType(opImm, rd, 3'(k), 5'(randomBits(5)),
						{7'h00, 5'(randomBits(5))}));
				else
					prog.push_back(iType(opImm, rd, 3'(k), 5'(randomBits(5)),
						12'(randomBits(12))));
				if (k == 5) // srai
					prog.push_back(iType(opImm, rd, 3'(k), 5'(randomBits(5)),
						{7'h20, 5'(randomBits(5))}));
			end
		end
		prog.push_back(ecallWord);
	endtask

	task automatic buildControlFlow();
		prog.delete();
		prog.push_back(uType(opAuipc, 5'd1, 20'(randomBits(20))));
		prog.push_back(jType(5'd2, 21'd8)); // Over the next word
		prog.push_back(iType(opImm, 5'd3, 3'b000, 5'd0, 12'd1));
		prog.push_back(uType(opAuipc, 5'd4, 20'd0)); // x4 = 12
		prog.push_back(iType(opJalr, 5'd5, 3'b000, 5'd4, 12'd17)); // Target 29 loses bit 0
		prog.push_back(iType(opImm, 5'd3, 3'b000, 5'd0, 12'd2));
		prog.push_back(iType(opImm, 5'd3, 3'b000, 5'd0, 12'd3));
		prog.push_back(iType(opImm, 5'd6, 3'b000, 5'd0, 12'hffb)); // -5
		prog.push_back(iType(opImm, 5'd7, 3'b000, 5'd0, 12'd3));
		for (int k = 0; k < 8; k++)
		begin
			if (k != 2 && k != 3)
			begin
				// Pairs (x6,x7), (x7,x6), (x6,x6)
				for (int p = 0; p < 3; p++)
				begin
					prog.push_back(bType(3'(k), (p == 1) ? 5'd7 : 5'd6, (p == 0) ? 5'd7 : 5'd6,
						13'd8));
					prog.push_back(iType(opImm, 5'd8, 3'b000, 5'd8, 12'd1)); // Skipped when taken
				end
			end
		end
		prog.push_back(iType(opImm, 5'd9, 3'b000, 5'd0, 12'd3));
		prog.push_back(iType(opImm, 5'd9, 3'b000, 5'd9, 12'hfff)); // Loop body
		prog.push_back(bType(3'b001, 5'd9, 5'd0, 13'h1ffc)); // Back by 4
		prog.push_back(jType(5'd0, 21'd8)); // No link
		prog.push_back(iType(opImm, 5'd3, 3'b000, 5'd0, 12'd4));
		prog.push_back(32'h0000_000f); // fence
		prog.push_back(ecallWord);
	endtask

	task automatic buildMemory();
		logic [11:0] offset;
		prog.delete();
		prog.push_back(iType(opImm, 5'd5, 3'b000, 5'd0, 12'h600)); // Data base
		for (int round = 0; round < 10; round++)
		begin
			offset = 12'(randomBits(6) << 2) - 12'd128; // Aligned offset of either sign
			prog.push_back(uType(opLui, 5'd6, 20'(randomBits(20))));
			prog.push_back(iType(opImm, 5'd6, 3'b000, 5'd6, 12'(randomBits(12))));
			prog.push_back(sType(3'b010, 5'd5, 5'd6, offset));
			prog.push_back(iType(opImm, 5'd6, 3'b000, 5'd6, 12'(randomBits(12))));
			prog.push_back(sType(3'b000, 5'd5, 5'd6, offset + 12'(randomBits(2))));
			prog.push_back(sType(3'b001, 5'd5, 5'd6, offset + 12'(randomBits(1) << 1)));
			prog.push_back(iType(opLoad, 5'd10, 3'b000, 5'd5, offset + 12'(randomBits(2))));
			prog.push_back(iType(opLoad, 5'd11, 3'b100, 5'd5, offset + 12'(randomBits(2))));
			prog.push_back(iType(opLoad, 5'd12, 3'b001, 5'd5, offset + 12'(randomBits(1) << 1)));
			prog.push_back(iType(opLoad, 5'd13, 3'b101, 5'd5, offset + 12'(randomBits(1) << 1)));
			prog.push_back(iType(opLoad, 5'd14, 3'b010, 5'd5, offset));
		end
		prog.push_back(ecallWord);
	endtask

	task automatic buildStop(input logic [31:0] stopWord);
		prog.delete();
		prog.push_back(iType(opImm, 5'd1, 3'b000, 5'd0, 12'd5));
		prog.push_back(iType(opImm, 5'd2, 3'b000, 5'd1, 12'd7));
		prog.push_back(stopWord);
		prog.push_back(iType(opImm, 5'd3, 3'b000, 5'd0, 12'd1)); // Never reached
	endtask

	task automatic buildFault(input logic [31:0] faultWord);
		prog.delete();
		prog.push_back(iType(opImm, 5'd1, 3'b000, 5'd0, 12'h102)); // Odd jump target
		prog.push_back(iType(opImm, 5'd5, 3'b000, 5'd0, 12'h601)); // Odd data address
		prog.push_back(faultWord);
		prog.push_back(iType(opImm, 5'd3, 3'b000, 5'd0, 12'd1));
		prog.push_back(ecallWord);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		loadStrobe = 1'b0;
		loadAddress = '0;
		loadData = 32'd0;
		running = 1'b0;
		lfsrState = 16'd60;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		buildArithmetic();
		runProgram("arithmetic", causeStop);
		buildControlFlow();
		runProgram("control flow", causeStop);
		buildMemory();
		runProgram("memory", causeStop);
		buildStop(ecallWord);
		runProgram("ecall stop", causeStop);
		runProgram("restart after halt", causeStop); // Same image after a second reset
		buildStop(ebreakWord);
		runProgram("ebreak stop", causeStop);
		buildFault(32'h0000_000b); // custom-0
		runProgram("bad opcode", causeBadOpcode);
		buildFault(iType(opImm, 5'd2, 3'b000, 5'd1, 12'd1) & 32'hffff_fffc);
		runProgram("bad low opcode", causeBadLowOpcode);
		buildFault(iType(opJalr, 5'd2, 3'b000, 5'd1, 12'd0));
		runProgram("misaligned jalr", causePcMisaligned);
		buildFault(iType(opLoad, 5'd6, 3'b010, 5'd5, 12'd0));
		runProgram("unaligned lw", causeUnaligned);
		buildFault(bType(3'b010, 5'd1, 5'd5, 13'd8));
		runProgram("branch funct3 2", causeBadFunct3);
		$display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- CoreTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module CoreTop
(
	input logic clock,
	input logic reset,
	input logic loadStrobe,
	input logic [`MEM_ADDR_BITS-1:0] loadAddress, // Word address
	input logic [`XLEN-1:0] loadData,
	output logic retireStrobe,
	output logic [`XLEN-1:0] retirePc,
	output logic retireWrite, // Register other than x0 written
	output logic [4:0] retireRd,
	output logic [`XLEN-1:0] retireValue,
	output logic halted,
	output CoreIsaTypes::HaltCause_t haltCause
);
	import CoreControlTypes::*;

	logic [31:0] instruction;
	logic [`XLEN-1:0] rs1Data, rs2Data, rdData;
	logic [`XLEN-1:0] aluResult, immediateValue, loadResult;
	logic [`XLEN-1:0] pc, nextPc, linkValue, fetchAddress;
	logic branchBadFunct3, pcMisaligned, unalignedAccess, memoryBadFunct3;
	logic rdWriteEnable, pcWriteEnable, opImm;
	RdSource_t rdSource;
	MemoryMode_t memoryMode;
	InstructionAddressSource_t instructionAddressSource;
	ImmediateFormerMode_t immediateFormerMode;
	BranchALUMode_t branchMode;

	ControlLogic control0
	(
		.clock, .reset,
		.opcode(instruction[6:0]), .funct3(instruction[14:12]),
		.branchBadFunct3, .pcMisaligned, .unalignedAccess, .memoryBadFunct3,
		.rdWriteEnable, .rdSource, .memoryMode, .pcWriteEnable, .instructionAddressSource,
		.opImm, .immediateFormerMode, .branchMode,
		.retireStrobe, .halted, .haltCause
	);

	RegisterFile registers0
	(
		.clock, .reset,
		.rs1Index(instruction[19:15]), .rs2Index(instruction[24:20]), .rdIndex(instruction[11:7]),
		.rdWriteEnable, .rdData, .rs1Data, .rs2Data
	);

	Alu alu0 (.instruction, .rs1Data, .rs2Data, .opImm, .result(aluResult));

	ImmediateFormer immediate0 (.instruction, .pc, .immediateFormerMode, .value(immediateValue));

	BranchUnit branch0
	(
		.clock, .reset, .instruction, .rs1Data, .rs2Data, .branchMode, .pcWriteEnable,
		.pc, .nextPc, .linkValue, .branchBadFunct3, .pcMisaligned
	);

	MemoryController memory0
	(
		.clock, .reset, .loadStrobe, .loadAddress, .loadData,
		.fetchAddress, .memoryMode, .instruction, .rs1Data, .rs2Data,
		.fetchedInstruction(instruction), .loadResult, .unalignedAccess, .memoryBadFunct3
	);

	// Next pc on completion, otherwise refetch the current one
	assign fetchAddress = (instructionAddressSource == NEXT_PC) ? nextPc : pc;

	always_comb
	begin
		case (rdSource)
			MEMORY: rdData = loadResult;
			IMMEDIATE: rdData = immediateValue; // lui/auipc
			BRANCH_UNIT: rdData = linkValue;
			default: rdData = aluResult;
		endcase
	end

	// Trace of the instruction completing this cycle
	assign retirePc = pc;
	assign retireWrite = rdWriteEnable && (instruction[11:7] != 5'd0);
	assign retireRd = instruction[11:7];
	assign retireValue = rdData;

endmodule

`default_nettype wire

//--- MemoryController.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module MemoryController
(
	input logic clock,
	input logic reset,
	input logic loadStrobe, // Program load strobe honoured during reset
	input logic [`MEM_ADDR_BITS-1:0] loadAddress,
	input logic [`XLEN-1:0] loadData,
	input logic [`XLEN-1:0] fetchAddress,
	input CoreControlTypes::MemoryMode_t memoryMode,
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] rs1Data,
	input logic [`XLEN-1:0] rs2Data,
	output logic [31:0] fetchedInstruction,
	output logic [`XLEN-1:0] loadResult,
	output logic unalignedAccess,
	output logic memoryBadFunct3
);
	import CoreControlTypes::*;

	logic [`XLEN-1:0] memory [`MEM_WORDS];
	logic [2:0] funct3;
	logic [`XLEN-1:0] offset, dataAddress;
	logic [`XLEN-1:0] dataWord; // Registered data port output
	logic [`XLEN-1:0] shiftedWord, laneMask, mergedWord;
	logic [4:0] laneShift;
	logic writeEnable;
	logic [`MEM_ADDR_BITS-1:0] writeIndex;
	logic [`XLEN-1:0] writeData;

	assign funct3 = instruction[14:12];
	assign offset = (memoryMode == LOAD)
		? {{(`XLEN-12){instruction[31]}}, instruction[31:20]} // I-type
		: {{(`XLEN-12){instruction[31]}}, instruction[31:25], instruction[11:7]}; // S-type
	assign dataAddress = rs1Data + offset;
	assign laneShift = {dataAddress[1:0], 3'b000};

	always_comb
	begin
		// Half and word need natural alignment
		// Size 3 is left to the funct3 check
		unalignedAccess = (memoryMode != NOP)
			&& ((funct3[1:0] == 2'b01 && dataAddress[0])
			|| (funct3[1:0] == 2'b10 && dataAddress[1:0] != 2'b00));
		if (memoryMode == LOAD)
			memoryBadFunct3 = (funct3[1:0] == 2'b11) || (funct3[2:1] == 2'b11);
		else
			memoryBadFunct3 = (memoryMode != NOP) && (funct3[2] || funct3[1:0] == 2'b11);
	end

	assign shiftedWord = dataWord >> laneShift; // Addressed lane to bit 0

	always_comb
	begin
		case (funct3)
			3'b000: loadResult = {{(`XLEN-8){shiftedWord[7]}}, shiftedWord[7:0]}; // lb
			3'b001: loadResult = {{(`XLEN-16){shiftedWord[15]}}, shiftedWord[15:0]}; // lh
			3'b100: loadResult = {{(`XLEN-8){1'b0}}, shiftedWord[7:0]}; // lbu
			3'b101: loadResult = {{(`XLEN-16){1'b0}}, shiftedWord[15:0]}; // lhu
			default: loadResult = shiftedWord; // lw
		endcase
		case (funct3[1:0])
			2'b00: laneMask = 32'h0000_00ff << laneShift;
			2'b01: laneMask = 32'h0000_ffff << laneShift;
			default: laneMask = '1; // sw replaces the whole word
		endcase
	end

	assign mergedWord = (dataWord & ~laneMask) | ((rs2Data << laneShift) & laneMask);

	// Single write port shared by program load and stores
	assign writeEnable = reset ? loadStrobe
		: (memoryMode == STORE && !unalignedAccess && !memoryBadFunct3);
	assign writeIndex = reset ? loadAddress : dataAddress[`MEM_ADDR_BITS+1:2];
	assign writeData = reset ? loadData : mergedWord;

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			memory[writeIndex] <= writeData;
		fetchedInstruction <= memory[fetchAddress[`MEM_ADDR_BITS+1:2]];
		if (memoryMode == LOAD || memoryMode == STORE_PRELOAD)
			dataWord <= memory[dataAddress[`MEM_ADDR_BITS+1:2]];
	end

endmodule

`default_nettype wire

//--- BranchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module BranchUnit
(
	input logic clock,
	input logic reset,
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] rs1Data,
	input logic [`XLEN-1:0] rs2Data,
	input CoreControlTypes::BranchALUMode_t branchMode,
	input logic pcWriteEnable,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] nextPc,
	output logic [`XLEN-1:0] linkValue,
	output logic branchBadFunct3,
	output logic pcMisaligned
);
	import CoreControlTypes::*;

	logic [2:0] funct3;
	logic [`XLEN-1:0] branchOffset, jumpOffset, jalrOffset;
	logic [`XLEN-1:0] sequentialPc;
	logic taken;

	assign funct3 = instruction[14:12];
	assign branchOffset = {{(`XLEN-12){instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0}; // B-type
	assign jumpOffset = {{(`XLEN-20){instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0}; // J-type
	assign jalrOffset = {{(`XLEN-12){instruction[31]}}, instruction[31:20]};
	assign sequentialPc = pc + 32'd4;

	always_comb
	begin
		case (funct3)
			3'b000: taken = (rs1Data == rs2Data); // beq
			3'b001: taken = (rs1Data != rs2Data);
			3'b100: taken = ($signed(rs1Data) < $signed(rs2Data)); // blt
			3'b101: taken = ($signed(rs1Data) >= $signed(rs2Data));
			3'b110: taken = (rs1Data < rs2Data); // bltu
			3'b111: taken = (rs1Data >= rs2Data);
			default: taken = 1'b0; // 2 and 3 undefined
		endcase
		case (branchMode)
			BRANCH: nextPc = taken ? pc + branchOffset : sequentialPc;
			JAL: nextPc = pc + jumpOffset;
			JALR: nextPc = (rs1Data + jalrOffset) & ~32'd1; // Bit 0 dropped
			default: nextPc = sequentialPc;
		endcase
	end

	assign branchBadFunct3 = (branchMode == BRANCH) && (funct3[2:1] == 2'b01);
	assign pcMisaligned = (nextPc[1:0] != 2'b00);
	assign linkValue = sequentialPc;

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= `RESET_PC;
		else if (pcWriteEnable)
			pc <= nextPc;
	end

endmodule

`default_nettype wire

//--- ImmediateFormer.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module ImmediateFormer
(
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] pc,
	input CoreControlTypes::ImmediateFormerMode_t immediateFormerMode,
	output logic [`XLEN-1:0] value
);
	import CoreControlTypes::*;

	logic [`XLEN-1:0] upperImmediate;

	// U-type immediate, low 12 bits zero
	assign upperImmediate = {instruction[31:12], 12'b0};

	always_comb
	begin
		case (immediateFormerMode)
			AUIPC: value = pc + upperImmediate; // Relative to this instruction
			default: value = upperImmediate; // lui
		endcase
	end

endmodule

`default_nettype wire

//--- Alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module Alu
(
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] rs1Data,
	input logic [`XLEN-1:0] rs2Data,
	input logic opImm, // OP-IMM when high
	output logic [`XLEN-1:0] result
);
	logic [2:0] funct3;
	logic [`XLEN-1:0] immediate;
	logic [`XLEN-1:0] operandB;
	logic [4:0] shiftAmount;

	assign funct3 = instruction[14:12];
	assign immediate = {{(`XLEN-12){instruction[31]}}, instruction[31:20]}; // I-type
	assign operandB = opImm ? immediate : rs2Data;
	assign shiftAmount = operandB[4:0]; // shamt or rs2[4:0]

	always_comb
	begin
		case (funct3)
			3'b000: // No subi, so bit 30 only counts for OP
				result = (!opImm && instruction[30]) ? rs1Data - operandB : rs1Data + operandB;
			3'b001: result = rs1Data << shiftAmount;
			3'b010: result = {{(`XLEN-1){1'b0}}, $signed(rs1Data) < $signed(operandB)};
			3'b011: result = {{(`XLEN-1){1'b0}}, rs1Data < operandB};
			3'b100: result = rs1Data ^ operandB;
			3'b101:
			begin
				if (instruction[30]) // sra/srai
					result = $signed(rs1Data) >>> shiftAmount;
				else
					result = rs1Data >> shiftAmount;
			end
			3'b110: result = rs1Data | operandB;
			default: result = rs1Data & operandB;
		endcase
	end

endmodule

`default_nettype wire

//--- RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module RegisterFile
(
	input logic clock,
	input logic reset,
	input logic [4:0] rs1Index,
	input logic [4:0] rs2Index,
	input logic [4:0] rdIndex,
	input logic rdWriteEnable,
	input logic [`XLEN-1:0] rdData,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data
);
	logic [`XLEN-1:0] registers [`REG_COUNT];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				registers[i] <= '0;
		end
		else if (rdWriteEnable && rdIndex != 5'd0) // x0 stays zero
			registers[rdIndex] <= rdData;
	end

	// Combinational reads, new value visible next instruction
	assign rs1Data = registers[rs1Index];
	assign rs2Data = registers[rs2Index];

endmodule

`default_nettype wire

//--- ControlLogic.sv
`timescale 1ns/1ps
`default_nettype none

module ControlLogic
(
	input logic clock,
	input logic reset,
	input logic [6:0] opcode,
	input logic [2:0] funct3,
	input logic branchBadFunct3, // From BranchUnit
	input logic pcMisaligned,
	input logic unalignedAccess, // From MemoryController
	input logic memoryBadFunct3,
	output logic rdWriteEnable,
	output CoreControlTypes::RdSource_t rdSource,
	output CoreControlTypes::MemoryMode_t memoryMode,
	output logic pcWriteEnable,
	output CoreControlTypes::InstructionAddressSource_t instructionAddressSource,
	output logic opImm,
	output CoreControlTypes::ImmediateFormerMode_t immediateFormerMode,
	output CoreControlTypes::BranchALUMode_t branchMode,
	output logic retireStrobe,
	output logic halted,
	output CoreIsaTypes::HaltCause_t haltCause
);
	import CoreIsaTypes::*;
	import CoreControlTypes::*;

	Opcode_t majorOpcode;
	State_t stateReg; // Never holds EXECUTE
	State_t currentState; // Effective state
	State_t nextState;
	HaltCause_t cause;
	logic secondHalf; // EXECUTE cycle already done
	logic isTwoCycle;
	logic halt;
	logic rdWriteRaw, pcWriteRaw; // Before halt suppression
	logic badOpcode, stop;

	assign majorOpcode = Opcode_t'(opcode[6:2]);
	assign isTwoCycle = (majorOpcode == CoreIsaTypes::LOAD)
		|| (majorOpcode == CoreIsaTypes::STORE && funct3 != 3'b010); // sw is single cycle

	// Fresh two-cycle instruction runs its first cycle as EXECUTE
	assign currentState = (stateReg == FETCH_EXECUTE && isTwoCycle && !secondHalf)
		? EXECUTE : stateReg;

	always_comb
	begin
		rdWriteRaw = 1'b0;
		rdSource = ALU;
		memoryMode = NOP;
		pcWriteRaw = 1'b0;
		instructionAddressSource = CURRENT_PC; // Also the INITIAL_FETCH address
		opImm = 1'b0;
		immediateFormerMode = CoreControlTypes::LUI;
		branchMode = INCREMENT;
		badOpcode = 1'b0;
		stop = 1'b0;
		if (currentState == FETCH_EXECUTE)
		begin
			pcWriteRaw = 1'b1;
			instructionAddressSource = NEXT_PC; // Fetch the following instruction now
			case (majorOpcode)
				CoreIsaTypes::LUI, CoreIsaTypes::AUIPC:
				begin
					rdWriteRaw = 1'b1;
					rdSource = IMMEDIATE;
					immediateFormerMode = ImmediateFormerMode_t'(!opcode[5]); // Bit 5 set for lui
				end
				CoreIsaTypes::JAL, CoreIsaTypes::JALR:
				begin
					rdWriteRaw = 1'b1;
					rdSource = BRANCH_UNIT; // Link value
					branchMode = opcode[3] ? CoreControlTypes::JAL : CoreControlTypes::JALR;
				end
				CoreIsaTypes::BRANCH: branchMode = CoreControlTypes::BRANCH;
				CoreIsaTypes::LOAD:
				begin
					rdWriteRaw = 1'b1; // Data read in EXECUTE
					rdSource = MEMORY;
					memoryMode = CoreControlTypes::LOAD;
				end
				CoreIsaTypes::STORE: memoryMode = CoreControlTypes::STORE; // Merged word written
				CoreIsaTypes::OP, CoreIsaTypes::OP_IMM:
				begin
					rdWriteRaw = 1'b1;
					opImm = (majorOpcode == OP_IMM);
				end
				CoreIsaTypes::MISC_MEM:
				begin
					// fence behaves as a nop
				end
				CoreIsaTypes::SYSTEM:
				begin
					pcWriteRaw = 1'b0; // Clean stop leaves pc on the ecall
					stop = 1'b1;
				end
				default: badOpcode = 1'b1;
			endcase
		end
		else if (currentState == EXECUTE)
		begin
			if (majorOpcode == CoreIsaTypes::LOAD)
				memoryMode = CoreControlTypes::LOAD; // Issue the data read
			else
				memoryMode = STORE_PRELOAD; // Old word for sb/sh merge
		end
	end

	// First cause wins, checked only while executing
	always_comb
	begin
		cause = NONE;
		if (currentState == FETCH_EXECUTE || currentState == EXECUTE)
		begin
			if (opcode[1:0] != 2'b11)
				cause = BAD_LOW_OPCODE;
			else if (badOpcode)
				cause = BAD_OPCODE;
			else if (stop)
				cause = STOP;
			else if (pcMisaligned)
				cause = PC_MISALIGNED;
			else if (unalignedAccess)
				cause = UNALIGNED_ACCESS;
			else if (branchBadFunct3 || memoryBadFunct3)
				cause = BAD_FUNCT3;
		end
	end

	assign halt = (cause != NONE);
	assign nextState = (halt || stateReg == HALT) ? HALT : FETCH_EXECUTE;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stateReg <= INITIAL_FETCH;
			secondHalf <= 1'b0;
			haltCause <= NONE;
		end
		else
		begin
			stateReg <= nextState;
			secondHalf <= (currentState == EXECUTE) && !halt;
			if (halt)
				haltCause <= cause; // Held until reset
		end
	end

	// Faulting instruction leaves no trace
	assign rdWriteEnable = rdWriteRaw && !halt;
	assign pcWriteEnable = pcWriteRaw && !halt;
	assign retireStrobe = (currentState == FETCH_EXECUTE) && !halt;
	assign halted = (stateReg == HALT);

endmodule

`default_nettype wire

//--- CoreControlTypes.sv
`default_nettype none

package CoreControlTypes;

	typedef enum logic [1:0]
	{
		INITIAL_FETCH,
		FETCH_EXECUTE,
		EXECUTE, // First cycle of loads, sb and sh
		HALT
	} State_t;

	typedef enum logic [1:0] {NOP, LOAD, STORE_PRELOAD, STORE} MemoryMode_t;

	// rd write data source
	typedef enum logic [1:0] {MEMORY, ALU, IMMEDIATE, BRANCH_UNIT} RdSource_t;

	// Fetch address select
	typedef enum logic {CURRENT_PC, NEXT_PC} InstructionAddressSource_t;

	typedef enum logic {LUI, AUIPC} ImmediateFormerMode_t;

	// Next pc computation
	typedef enum logic [1:0] {INCREMENT, BRANCH, JAL, JALR} BranchALUMode_t;

endpackage

`default_nettype wire

//--- CoreIsaTypes.sv
`default_nettype none

package CoreIsaTypes;

	// Major opcode, instruction bits 6:2
	typedef enum logic [4:0]
	{
		LOAD = 5'b00000,
		MISC_MEM = 5'b00011, // fence
		OP_IMM = 5'b00100,
		AUIPC = 5'b00101,
		STORE = 5'b01000,
		OP = 5'b01100,
		LUI = 5'b01101,
		BRANCH = 5'b11000,
		JALR = 5'b11001,
		JAL = 5'b11011,
		SYSTEM = 5'b11100 // ecall/ebreak
	} Opcode_t;

	// Why the core stopped
	typedef enum logic [2:0]
	{
		NONE = 3'd0, // Still running
		STOP = 3'd1, // Clean stop by ecall/ebreak
		BAD_OPCODE = 3'd2,
		BAD_LOW_OPCODE = 3'd3, // Bits 1:0 not 2'b11
		PC_MISALIGNED = 3'd4,
		UNALIGNED_ACCESS = 3'd5,
		BAD_FUNCT3 = 3'd6 // Branch or load/store
	} HaltCause_t;

endpackage

`default_nettype wire

//--- core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path width
`define XLEN 32

// General registers, x0 included
`define REG_COUNT 32

// Unified memory in 32-bit words
`define MEM_WORDS 1024
`define MEM_ADDR_BITS 10 // log2 of MEM_WORDS

`define RESET_PC 32'h0000_0000 // First fetch after reset

`endif
